//--- rtl/chess_pkg.sv
//////////////////////////////////////////////////
// chess co-processor shared definitions
//////////////////////////////////////////////////

package chess_pkg;

    // field widths
    localparam int BYTE_W     = 8;
    localparam int SM_W       = 3;
    localparam int MM_W       = 2;
    localparam int SQ_W       = 6;
    localparam int WB_W       = 4;
    localparam int CORE_IDX_W = 3;  // low bits of SET-CORE

    // largest core count SET-CORE can address
    localparam int MAX_CORES = 1 << CORE_IDX_W;

    typedef logic [BYTE_W-1:0]     usb_byte_t;
    typedef logic [SM_W-1:0]       state_mode_t;
    typedef logic [MM_W-1:0]       mask_mode_t;
    typedef logic [SQ_W-1:0]       square_t;
    typedef logic [WB_W-1:0]       write_bus_t;
    typedef logic [CORE_IDX_W-1:0] core_idx_t;

    // reset values
    localparam state_mode_t SM_IDLE      = '0;
    localparam mask_mode_t  MM_NO_CHANGE = '0;

    // opcode class, top two bits of a command byte
    localparam logic [1:0] CLS_WRITE = 2'b00;
    localparam logic [1:0] CLS_READ  = 2'b01;
    localparam logic [1:0] CLS_SS1   = 2'b10;
    localparam logic [1:0] CLS_SS2   = 2'b11;

    // 0001_1xxx selects core xxx
    localparam logic [4:0] OP_SET_CORE = 5'b00011;

endpackage

//--- rtl/core_regs.sv
//////////////////////////////////////////////////
// per-core search registers
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_regs (
    input  logic                    clk60,
    input  logic                    gateware_reset,
    input  logic                    rx_next_i,
    input  chess_pkg::usb_byte_t    rx_data_i,
    output chess_pkg::state_mode_t  state_mode_o,
    output chess_pkg::mask_mode_t   mask_mode_o,
    output logic                    wtm_o,
    output chess_pkg::write_bus_t   write_bus_o,
    output chess_pkg::square_t      ss1_o,
    output logic                    ss1_valid_o,
    output chess_pkg::square_t      ss2_o,
    output logic                    ss2_valid_o
);

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset) begin
            state_mode_o <= chess_pkg::SM_IDLE;
            mask_mode_o  <= chess_pkg::MM_NO_CHANGE;
            wtm_o        <= 1'b0;
            write_bus_o  <= '0;
            ss1_o        <= '0;
            ss1_valid_o  <= 1'b0;
            ss2_o        <= '0;
            ss2_valid_o  <= 1'b0;
        end else if (rx_next_i) begin
            case (rx_data_i[7:6])
                chess_pkg::CLS_WRITE: begin
                    casez (rx_data_i[5:0])
                        6'b00000?: wtm_o        <= rx_data_i[0];
                        6'b00010?: ss1_valid_o  <= rx_data_i[0];
                        6'b00011?: ss2_valid_o  <= rx_data_i[0];
                        6'b0010??: mask_mode_o  <= rx_data_i[1:0];
                        6'b010???: state_mode_o <= rx_data_i[2:0];
                        6'b10????: write_bus_o  <= rx_data_i[3:0];
                        // 0000_001x, 0000_11xx, SET-CORE and 0011_xxxx are no-ops
                        default: ;
                    endcase
                end
                chess_pkg::CLS_SS1: ss1_o <= rx_data_i[5:0];
                chess_pkg::CLS_SS2: ss2_o <= rx_data_i[5:0];
                default: ;  // reads handled by reply_ctrl
            endcase
        end
    end

endmodule

//--- rtl/reply_ctrl.sv
//////////////////////////////////////////////////
// read decode and reply byte
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reply_ctrl (
    input  logic                    clk60,
    input  logic                    gateware_reset,
    input  logic                    rx_next_i,
    input  chess_pkg::usb_byte_t    rx_data_i,
    input  logic                    tx_ready_i,
    input  chess_pkg::state_mode_t  state_mode_i,
    input  chess_pkg::mask_mode_t   mask_mode_i,
    input  logic                    wtm_i,
    input  chess_pkg::write_bus_t   write_bus_i,
    input  chess_pkg::square_t      ss1_i,
    input  logic                    ss1_valid_i,
    input  chess_pkg::square_t      ss2_i,
    input  logic                    ss2_valid_i,
    output logic                    busy_o,
    output logic                    tx_valid_o,
    output chess_pkg::usb_byte_t    tx_data_o
);

    typedef enum logic {ST_IDLE, ST_WAIT} reply_state_t;

    reply_state_t         state;
    chess_pkg::usb_byte_t stored_cmd;
    chess_pkg::usb_byte_t cmd_sel;
    chess_pkg::usb_byte_t reply;
    logic                 is_read;

    assign is_read = rx_next_i && (rx_data_i[7:6] == chess_pkg::CLS_READ);
    assign busy_o  = (state == ST_WAIT);
    assign cmd_sel = (state == ST_WAIT) ? stored_cmd : rx_data_i;

    // one read table serves both the direct and the delayed reply
    always_comb begin
        casez (cmd_sel[5:0])
            6'b00000?: reply = chess_pkg::usb_byte_t'(wtm_i);
            6'b000100: reply = {1'b0, ss1_valid_i, ss1_i};
            6'b000101: reply = {1'b0, ss2_valid_i, ss2_i};
            6'b001???: reply = chess_pkg::usb_byte_t'(mask_mode_i);
            6'b01????: reply = chess_pkg::usb_byte_t'(state_mode_i);
            6'b1?????: reply = chess_pkg::usb_byte_t'(write_bus_i);
            default:   reply = '0;  // GET-STATUS and unassigned codes
        endcase
    end

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset) begin
            state      <= ST_IDLE;
            tx_valid_o <= 1'b0;
            tx_data_o  <= '0;
        end else begin
            tx_valid_o <= 1'b0;
            tx_data_o  <= '0;
            case (state)
                ST_IDLE: begin
                    if (is_read) begin
                        if (tx_ready_i) begin
                            tx_valid_o <= 1'b1;
                            tx_data_o  <= reply;
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_WAIT: begin  // strobes ignored here
                    if (tx_ready_i) begin
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= reply;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk60) begin
        if (state == ST_IDLE && is_read && !tx_ready_i)
            stored_cmd <= rx_data_i;
    end

    a_single_pulse: assert property (@(posedge clk60) disable iff (gateware_reset)
        tx_valid_o |=> !tx_valid_o);

endmodule

//--- rtl/chess_core.sv
//////////////////////////////////////////////////
// chess core command front end
//////////////////////////////////////////////////

`timescale 1ns/1ps

module chess_core (
    input  logic                  clk60,
    input  logic                  gateware_reset,
    input  logic                  rx_next_i,
    input  chess_pkg::usb_byte_t  rx_data_i,
    input  logic                  tx_ready_i,
    output logic                  tx_valid_o,
    output chess_pkg::usb_byte_t  tx_data_o
);

    chess_pkg::state_mode_t state_mode;
    chess_pkg::mask_mode_t  mask_mode;
    logic                   wtm;
    chess_pkg::write_bus_t  write_bus;
    chess_pkg::square_t     ss1;
    logic                   ss1_valid;
    chess_pkg::square_t     ss2;
    logic                   ss2_valid;
    logic                   reply_busy;

    core_regs u_regs (
        .clk60          (clk60),
        .gateware_reset (gateware_reset),
        .rx_next_i      (rx_next_i && !reply_busy),  // writes dropped while a reply waits
        .rx_data_i      (rx_data_i),
        .state_mode_o   (state_mode),
        .mask_mode_o    (mask_mode),
        .wtm_o          (wtm),
        .write_bus_o    (write_bus),
        .ss1_o          (ss1),
        .ss1_valid_o    (ss1_valid),
        .ss2_o          (ss2),
        .ss2_valid_o    (ss2_valid)
    );

    reply_ctrl u_reply (
        .clk60          (clk60),
        .gateware_reset (gateware_reset),
        .rx_next_i      (rx_next_i),
        .rx_data_i      (rx_data_i),
        .tx_ready_i     (tx_ready_i),
        .state_mode_i   (state_mode),
        .mask_mode_i    (mask_mode),
        .wtm_i          (wtm),
        .write_bus_i    (write_bus),
        .ss1_i          (ss1),
        .ss1_valid_i    (ss1_valid),
        .ss2_i          (ss2),
        .ss2_valid_i    (ss2_valid),
        .busy_o         (reply_busy),
        .tx_valid_o     (tx_valid_o),
        .tx_data_o      (tx_data_o)
    );

endmodule

//--- rtl/core_select.sv
//////////////////////////////////////////////////
// core selection and reply mux
//////////////////////////////////////////////////

`timescale 1ns/1ps

module core_select #(
    parameter int NUM_CORES = 8
) (
    input  logic                                  clk60,
    input  logic                                  gateware_reset,
    input  logic                                  rx_next_i,
    input  chess_pkg::usb_byte_t                  rx_data_i,
    input  logic [NUM_CORES-1:0]                  core_tx_valid_i,
    input  chess_pkg::usb_byte_t [NUM_CORES-1:0]  core_tx_data_i,
    output logic [NUM_CORES-1:0]                  core_rx_next_o,
    output logic                                  tx_valid_o,
    output chess_pkg::usb_byte_t                  tx_data_o
);

    chess_pkg::core_idx_t sel_core;
    logic                 set_core;

    if (NUM_CORES < 1 || NUM_CORES > chess_pkg::MAX_CORES) begin : g_bad_num_cores
        $error("core_select: NUM_CORES out of range");
    end

    // out-of-range core numbers are ignored
    assign set_core = rx_next_i && (rx_data_i[7:3] == chess_pkg::OP_SET_CORE)
                      && (int'(rx_data_i[2:0]) < NUM_CORES);

    always_ff @(posedge clk60 or posedge gateware_reset) begin
        if (gateware_reset)
            sel_core <= '0;
        else if (set_core)
            sel_core <= rx_data_i[2:0];
    end

    // strobe only the selected core
    always_comb begin
        for (int i = 0; i < NUM_CORES; i++)
            core_rx_next_o[i] = rx_next_i && (int'(sel_core) == i);
    end

    assign tx_valid_o = core_tx_valid_i[sel_core];
    assign tx_data_o  = core_tx_data_i[sel_core];

    a_sel_in_range: assert property (@(posedge clk60) disable iff (gateware_reset)
        int'(sel_core) < NUM_CORES);

endmodule

//--- rtl/chess_chip.sv
//////////////////////////////////////////////////
// chess co-processor top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module chess_chip #(
    parameter int NUM_CORES = 8  // 1 to chess_pkg::MAX_CORES
) (
    input  logic                  clk60,
    input  logic                  gateware_reset,
    input  logic                  rx_next_i,
    input  chess_pkg::usb_byte_t  rx_data_i,
    input  logic                  tx_ready_i,
    output logic                  tx_valid_o,
    output chess_pkg::usb_byte_t  tx_data_o
);

    logic [NUM_CORES-1:0]                  core_rx_next;
    logic [NUM_CORES-1:0]                  core_tx_valid;
    chess_pkg::usb_byte_t [NUM_CORES-1:0]  core_tx_data;

    for (genvar g = 0; g < NUM_CORES; g++) begin : g_core
        chess_core u_core (
            .clk60          (clk60),
            .gateware_reset (gateware_reset),
            .rx_next_i      (core_rx_next[g]),
            .rx_data_i      (rx_data_i),
            .tx_ready_i     (tx_ready_i),
            .tx_valid_o     (core_tx_valid[g]),
            .tx_data_o      (core_tx_data[g])
        );
    end

    core_select #(
        .NUM_CORES (NUM_CORES)
    ) u_select (
        .clk60           (clk60),
        .gateware_reset  (gateware_reset),
        .rx_next_i       (rx_next_i),
        .rx_data_i       (rx_data_i),
        .core_tx_valid_i (core_tx_valid),
        .core_tx_data_i  (core_tx_data),
        .core_rx_next_o  (core_rx_next),
        .tx_valid_o      (tx_valid_o),
        .tx_data_o       (tx_data_o)
    );

endmodule

//--- dv/tb_vectors.svh
//////////////////////////////////////////////////
// command and reply table
//////////////////////////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns: command, reply expected, reply, write during wait, that write
typedef struct packed {
    chess_pkg::usb_byte_t cmd;
    logic                 has_reply;
    chess_pkg::usb_byte_t reply;
    logic                 inject;
    chess_pkg::usb_byte_t inject_cmd;
} vector_t;

localparam int NUM_ROWS = 40;

localparam vector_t VECTORS [NUM_ROWS] = '{
    '{8'h40, 1'b1, 8'h00, 1'b0, 8'h00},  // reset values
    '{8'h42, 1'b1, 8'h00, 1'b0, 8'h00},  // GET-STATUS
    '{8'h46, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h45, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h4C, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h53, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h7A, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h1B, 1'b0, 8'h00, 1'b0, 8'h00},  // select core 3
    '{8'hA7, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h44, 1'b1, 8'h27, 1'b0, 8'h00},
    '{8'h18, 1'b0, 8'h00, 1'b0, 8'h00},  // back to core 0
    '{8'h44, 1'b1, 8'h00, 1'b0, 8'h00},
    '{8'h1B, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h44, 1'b1, 8'h27, 1'b0, 8'h00},
    '{8'h18, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h01, 1'b0, 8'h00, 1'b0, 8'h00},  // write then read
    '{8'h40, 1'b1, 8'h01, 1'b0, 8'h00},
    '{8'h05, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h8B, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h44, 1'b1, 8'h4B, 1'b0, 8'h00},
    '{8'h07, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'hF5, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h45, 1'b1, 8'h75, 1'b0, 8'h00},
    '{8'h0A, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h4F, 1'b1, 8'h02, 1'b0, 8'h00},
    '{8'h15, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h57, 1'b1, 8'h05, 1'b0, 8'h00},
    '{8'h2C, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h7E, 1'b1, 8'h0C, 1'b0, 8'h00},
    '{8'h02, 1'b0, 8'h00, 1'b0, 8'h00},  // no-op codes
    '{8'h0D, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h3A, 1'b0, 8'h00, 1'b0, 8'h00},
    '{8'h18, 1'b0, 8'h00, 1'b0, 8'h00},  // SET-CORE seen by core 0
    '{8'h4A, 1'b1, 8'h02, 1'b0, 8'h00},
    '{8'h50, 1'b1, 8'h05, 1'b0, 8'h00},
    '{8'h60, 1'b1, 8'h0C, 1'b0, 8'h00},
    '{8'h44, 1'b1, 8'h4B, 1'b1, 8'h80},  // ss1 clear must be dropped
    '{8'h40, 1'b1, 8'h01, 1'b1, 8'h00},
    '{8'h44, 1'b1, 8'h4B, 1'b0, 8'h00},
    '{8'h40, 1'b1, 8'h01, 1'b0, 8'h00}
};

`endif

//--- dv/tb_chess_chip.sv
//////////////////////////////////////////////////
// chess chip testbench
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_chess_chip;

    `include "tb_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_ROWS * 12 + 50;

    logic                 clk60;
    logic                 gateware_reset;
    logic                 rx_next;
    chess_pkg::usb_byte_t rx_data;
    logic                 tx_ready;
    logic                 tx_valid;
    chess_pkg::usb_byte_t tx_data;
    logic [15:0]          lfsr_state;
    int                   cycle_count;

    chess_chip dut0 (
        .clk60          (clk60),
        .gateware_reset (gateware_reset),
        .rx_next_i      (rx_next),
        .rx_data_i      (rx_data),
        .tx_ready_i     (tx_ready),
        .tx_valid_o     (tx_valid),
        .tx_data_o      (tx_data)
    );

    initial begin
        clk60 = 1'b0;
        forever #20 clk60 = ~clk60;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_hold(output int hold);
        hold = 0;
        for (int b = 0; b < 2; b++) begin
            hold = (hold << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reply(input int row, input chess_pkg::usb_byte_t expected);
        if (tx_data !== expected)
            stop_on_error($sformatf("FAIL %0t: row %0d cmd %02h replied %02h, expected %02h",
                                    $time, row, VECTORS[row].cmd, tx_data, expected));
    endtask

    task automatic check_silent(input int row);
        if (tx_valid !== 1'b0 || tx_data !== '0)
            stop_on_error($sformatf("FAIL %0t: row %0d cmd %02h stray reply, valid %b data %02h",
                                    $time, row, VECTORS[row].cmd, tx_valid, tx_data));
    endtask

    task automatic run_row(input int r);
        int hold;
        draw_hold(hold);
        if (VECTORS[r].inject && hold == 0)
            hold = 1;  // need a wait cycle to strobe into
        @(posedge clk60);
        rx_next  <= 1'b1;
        rx_data  <= VECTORS[r].cmd;
        tx_ready <= (hold == 0);
        for (int c = 0; c < hold; c++) begin
            @(posedge clk60);
            if (VECTORS[r].inject && c == 0) begin
                rx_next <= 1'b1;
                rx_data <= VECTORS[r].inject_cmd;
            end else begin
                rx_next <= 1'b0;
            end
        end
        @(posedge clk60);
        rx_next  <= 1'b0;
        tx_ready <= 1'b1;
        @(negedge clk60);
        if (VECTORS[r].has_reply) begin
            while (tx_valid !== 1'b1)
                @(negedge clk60);
            check_reply(r, VECTORS[r].reply);
            @(negedge clk60);
            check_silent(r);  // pulse must be one cycle
        end else begin
            repeat (4) begin
                check_silent(r);
                @(negedge clk60);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk60);
            cycle_count++;
        end
        stop_on_error($sformatf("timeout: test did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin
        gateware_reset <= 1'b1;
        rx_next        <= 1'b0;
        rx_data        <= '0;
        tx_ready       <= 1'b1;
        lfsr_state = 16'd41696;
        repeat (5) @(posedge clk60);
        gateware_reset <= 1'b0;
        @(posedge clk60);
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
rtl/chess_pkg.sv
rtl/core_regs.sv
rtl/reply_ctrl.sv
rtl/chess_core.sv
rtl/core_select.sv
rtl/chess_chip.sv
dv/tb_chess_chip.sv

//--- run_sim.sh
#!/bin/sh
# build and run the chess chip simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_chess_chip -o sim_chess_chip
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_chess_chip)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
